//--- hdl/board_io_pkg.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board I/O shared definitions
// Timing constants, register map, status structs and bus FSM states
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package board_io_pkg;

    // Input conditioning
    localparam int gpio_width     = 13;
    localparam int debounce_rate  = 4;
    localparam int debounce_depth = 4;
    localparam int sync_stages    = 2;

    // Register map
    localparam int addr_width = 8;
    localparam logic [addr_width-1:0] reg_status_addr = 8'h00;
    localparam logic [addr_width-1:0] reg_event_addr  = 8'h04;
    localparam logic [addr_width-1:0] reg_led_addr    = 8'h08;
    localparam logic [addr_width-1:0] reg_id_addr     = 8'h0c;
    localparam logic [31:0] board_id = 32'h10c4_0001;

    localparam logic [1:0] resp_okay   = 2'b00;
    localparam logic [1:0] resp_slverr = 2'b10;

    typedef struct packed {
        logic       btnu;
        logic       btnl;
        logic       btnd;
        logic       btnr;
        logic       btnc;
        logic [7:0] sw;
    } gpio_levels_t;

    // Levels in 5:4, one-cycle edge pulses in 3:0
    typedef struct packed {
        logic rxd;
        logic rts;
        logic rxd_rise;
        logic rxd_fall;
        logic rts_rise;
        logic rts_fall;
    } uart_ctrl_t;

    typedef enum logic {wr_idle, wr_resp} wr_state_t;
    typedef enum logic {rd_idle, rd_data} rd_state_t;

endpackage

`default_nettype wire

//--- hdl/debounce_switch.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Debouncer for the push buttons and slide switches
// Samples every input at a slow rate and only follows a stable history
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module debounce_switch (
    input  logic                       clk,
    input  logic                       rst_n,
    input  board_io_pkg::gpio_levels_t pins,
    output board_io_pkg::gpio_levels_t levels
);

    import board_io_pkg::*;

    localparam int cnt_width = (debounce_rate > 1) ? $clog2(debounce_rate) : 1;

    logic [cnt_width-1:0]      rate_cnt;
    logic                      sample;
    logic [debounce_depth-1:0] history [gpio_width];
    logic [gpio_width-1:0]     pin_bits;
    logic [gpio_width-1:0]     level_bits;

    assign pin_bits = pins;
    assign levels   = level_bits;

    // Sample strobe once per debounce_rate clocks
    assign sample = (rate_cnt == cnt_width'(debounce_rate - 1));

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rate_cnt <= '0;
        end else if (sample) begin
            rate_cnt <= '0;
        end else begin
            rate_cnt <= rate_cnt + 1'b1;
        end
    end

    // Per-input shift history; the output only moves once every
    // stored sample agrees, so short glitches are dropped
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < gpio_width; i++) begin
                history[i] <= '0;
            end
            level_bits <= '0;
        end else if (sample) begin
            for (int i = 0; i < gpio_width; i++) begin
                history[i] <= {history[i][debounce_depth-2:0], pin_bits[i]};
                if (&history[i]) begin
                    level_bits[i] <= 1'b1;
                end else if (~|history[i]) begin
                    level_bits[i] <= 1'b0;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/signal_sync_edge.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// UART control line synchronizer
// Brings rxd and rts into the clock domain and flags both edges
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module signal_sync_edge (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     uart_rxd,
    input  logic                     uart_rts,
    output board_io_pkg::uart_ctrl_t ctrl
);

    import board_io_pkg::*;

    // Bit 1 carries rxd, bit 0 carries rts
    logic [1:0] pin_sync [sync_stages];
    logic [1:0] line_now;

    // Idle level of both lines is high
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < sync_stages; i++) begin
                pin_sync[i] <= 2'b11;
            end
        end else begin
            pin_sync[0] <= {uart_rxd, uart_rts};
            for (int i = 1; i < sync_stages; i++) begin
                pin_sync[i] <= pin_sync[i-1];
            end
        end
    end

    assign line_now = pin_sync[sync_stages-1];

    // Registered level doubles as the delayed copy for edge detection
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ctrl <= '{rxd: 1'b1, rts: 1'b1, default: 1'b0};
        end else begin
            ctrl.rxd_rise <= line_now[1] & ~ctrl.rxd;
            ctrl.rxd_fall <= ~line_now[1] & ctrl.rxd;
            ctrl.rts_rise <= line_now[0] & ~ctrl.rts;
            ctrl.rts_fall <= ~line_now[0] & ctrl.rts;
            ctrl.rxd      <= line_now[1];
            ctrl.rts      <= line_now[0];
        end
    end

endmodule

`default_nettype wire

//--- hdl/gpio_axil_regs.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite GPIO register block
// Status, sticky UART events, LED control and a board identifier
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module gpio_axil_regs (
    input  logic                                clk,
    input  logic                                rst_n,
    input  board_io_pkg::gpio_levels_t          levels,
    input  board_io_pkg::uart_ctrl_t            ctrl,
    input  logic [board_io_pkg::addr_width-1:0] awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [31:0]                         wdata,
    input  logic [3:0]                          wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    input  logic [board_io_pkg::addr_width-1:0] araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [31:0]                         rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready,
    output logic [7:0]                          led
);

    import board_io_pkg::*;

    wr_state_t   wr_state;
    rd_state_t   rd_state;
    logic        wr_accept;
    logic        wr_led_hit;
    logic        wr_evt_hit;
    logic        wr_addr_ok;
    logic [3:0]  evt_flags;
    logic [3:0]  evt_clr;
    logic        rd_accept;
    logic [31:0] rd_mux;
    logic        rd_addr_ok;

    // Write channel: address and data must arrive together
    assign wr_accept = (wr_state == wr_idle) && awvalid && wvalid;
    assign awready   = wr_accept;
    assign wready    = wr_accept;
    assign bvalid    = (wr_state == wr_resp);

    assign wr_led_hit = (awaddr == reg_led_addr);
    assign wr_evt_hit = (awaddr == reg_event_addr);
    assign wr_addr_ok = wr_led_hit || wr_evt_hit ||
                        (awaddr == reg_status_addr) || (awaddr == reg_id_addr);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_state <= wr_idle;
        end else begin
            case (wr_state)
                wr_idle: if (wr_accept) wr_state <= wr_resp;
                wr_resp: if (bready) wr_state <= wr_idle;
                default: wr_state <= wr_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_accept) begin
            bresp <= wr_addr_ok ? resp_okay : resp_slverr;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            led <= '0;
        end else if (wr_accept && wr_led_hit && wstrb[0]) begin
            led <= wdata[7:0];
        end
    end

    // Sticky flags, a new edge wins over a simultaneous clear
    assign evt_clr = (wr_accept && wr_evt_hit && wstrb[0]) ? wdata[3:0] : 4'b0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            evt_flags <= '0;
        end else begin
            evt_flags <= (evt_flags & ~evt_clr) |
                         {ctrl.rxd_rise, ctrl.rxd_fall, ctrl.rts_rise, ctrl.rts_fall};
        end
    end

    // Read channel
    assign rd_accept = (rd_state == rd_idle) && arvalid;
    assign arready   = rd_accept;
    assign rvalid    = (rd_state == rd_data);

    always_comb begin
        rd_mux     = '0;
        rd_addr_ok = 1'b1;
        case (araddr)
            reg_status_addr: rd_mux = {14'b0, ctrl.rxd, ctrl.rts, 3'b0, levels};
            reg_event_addr:  rd_mux = {28'b0, evt_flags};
            reg_led_addr:    rd_mux = {24'b0, led};
            reg_id_addr:     rd_mux = board_id;
            default:         rd_addr_ok = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_state <= rd_idle;
        end else begin
            case (rd_state)
                rd_idle: if (rd_accept) rd_state <= rd_data;
                rd_data: if (rready) rd_state <= rd_idle;
                default: rd_state <= rd_idle;
            endcase
        end
    end

    // Held stable until rready
    always_ff @(posedge clk) begin
        if (rd_accept) begin
            rdata <= rd_mux;
            rresp <= rd_addr_ok ? resp_okay : resp_slverr;
        end
    end

endmodule

`default_nettype wire

//--- hdl/board_io_top.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board I/O top level
// Input conditioners feeding the AXI4-Lite GPIO register block
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module board_io_top (
    input  logic                                clk,
    input  logic                                rst_n,
    input  logic                                btnu,
    input  logic                                btnl,
    input  logic                                btnd,
    input  logic                                btnr,
    input  logic                                btnc,
    input  logic [7:0]                          sw,
    input  logic                                uart_rxd,
    input  logic                                uart_rts,
    output logic [7:0]                          led,
    input  logic [board_io_pkg::addr_width-1:0] awaddr,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [31:0]                         wdata,
    input  logic [3:0]                          wstrb,
    input  logic                                wvalid,
    output logic                                wready,
    output logic [1:0]                          bresp,
    output logic                                bvalid,
    input  logic                                bready,
    input  logic [board_io_pkg::addr_width-1:0] araddr,
    input  logic                                arvalid,
    output logic                                arready,
    output logic [31:0]                         rdata,
    output logic [1:0]                          rresp,
    output logic                                rvalid,
    input  logic                                rready
);

    import board_io_pkg::*;

    gpio_levels_t gpio_pins;
    gpio_levels_t gpio_levels;
    uart_ctrl_t   uart_ctrl;

    // Raw pins in struct order
    assign gpio_pins = {btnu, btnl, btnd, btnr, btnc, sw};

    debounce_switch debounce0 (
        .clk    (clk),
        .rst_n  (rst_n),
        .pins   (gpio_pins),
        .levels (gpio_levels)
    );

    signal_sync_edge sync0 (
        .clk      (clk),
        .rst_n    (rst_n),
        .uart_rxd (uart_rxd),
        .uart_rts (uart_rts),
        .ctrl     (uart_ctrl)
    );

    gpio_axil_regs regs0 (
        .clk     (clk),
        .rst_n   (rst_n),
        .levels  (gpio_levels),
        .ctrl    (uart_ctrl),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .led     (led)
    );

endmodule

`default_nettype wire

//--- verification/board_io_assert.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite handshake checks
// Bound to the GPIO register block
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module board_io_assert (
    input logic        clk,
    input logic        rst_n,
    input logic        awready,
    input logic        bvalid,
    input logic        bready,
    input logic        rvalid,
    input logic        rready,
    input logic [31:0] rdata
);

    timeunit 1ns;
    timeprecision 100ps;

    int unsigned fail_count = 0;

    // Write response stays up until taken
    assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else begin
            fail_count++;
            $error("bvalid dropped before bready");
        end

    assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> $stable(rdata))
        else begin
            fail_count++;
            $error("rdata changed while the read was stalled");
        end

    // No new write while a response is pending
    assert property (@(posedge clk) disable iff (!rst_n)
        awready || (bvalid && !bready) |=> !awready)
        else begin
            fail_count++;
            $error("awready high while bvalid is pending");
        end

endmodule

bind gpio_axil_regs board_io_assert assert0 (
    .clk     (clk),
    .rst_n   (rst_n),
    .awready (awready),
    .bvalid  (bvalid),
    .bready  (bready),
    .rvalid  (rvalid),
    .rready  (rready),
    .rdata   (rdata)
);

`default_nettype wire

//--- verification/board_io_tb.sv
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Board I/O testbench
// Replays the operations of the data file on the pins and the AXI4-Lite
// bus and compares every response with the expected value
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module board_io_tb;

    timeunit 1ns;
    timeprecision 100ps;

    import board_io_pkg::*;

    localparam int op_words   = 5;
    localparam int max_ops    = 64;
    localparam int hs_limit   = 40;
    localparam int poll_limit = 300;

    logic                  clk;
    logic                  rst_n;
    logic                  btnu;
    logic                  btnl;
    logic                  btnd;
    logic                  btnr;
    logic                  btnc;
    logic [7:0]            sw;
    logic                  uart_rxd;
    logic                  uart_rts;
    logic [7:0]            led;
    logic [addr_width-1:0] awaddr;
    logic                  awvalid;
    logic                  awready;
    logic [31:0]           wdata;
    logic [3:0]            wstrb;
    logic                  wvalid;
    logic                  wready;
    logic [1:0]            bresp;
    logic                  bvalid;
    logic                  bready;
    logic [addr_width-1:0] araddr;
    logic                  arvalid;
    logic                  arready;
    logic [31:0]           rdata;
    logic [1:0]            rresp;
    logic                  rvalid;
    logic                  rready;

    // Five words per operation: code and four arguments
    logic [31:0] ops [op_words*max_ops];
    int unsigned stall_max;

    board_io_top dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("test failed");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("[ERROR] %0t ns: %s is %h, expected %h", $time, what, got, exp);
            stop_with_failure();
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timed out while waiting for %s", what);
        stop_with_failure();
    endtask

    function automatic int pick_stall();
        return int'($urandom % (stall_max + 1));
    endfunction

    task automatic drive_pins(input logic [12:0] gpio, input logic [1:0] uart);
        {btnu, btnl, btnd, btnr, btnc, sw} = gpio;
        {uart_rxd, uart_rts} = uart;
    endtask

    // Short pulse, then status reads over the window in which a
    // glitch that got through the filter would be visible
    task automatic glitch_pins(input logic [12:0] gpio, input int clocks);
        logic [12:0] saved;
        logic [31:0] steady;
        saved  = {btnu, btnl, btnd, btnr, btnc, sw};
        steady = 32'(saved) | (32'({uart_rxd, uart_rts}) << 16);
        {btnu, btnl, btnd, btnr, btnc, sw} = gpio;
        repeat (clocks) @(negedge clk);
        {btnu, btnl, btnd, btnr, btnc, sw} = saved;
        // Each read takes at least two clocks
        repeat (debounce_rate * (debounce_depth + 1) / 2) begin
            check_read(32'(reg_status_addr), steady, resp_okay);
        end
    endtask

    task automatic axil_write(input logic [31:0] addr, input logic [31:0] data,
                              input logic [3:0] strb, input logic [1:0] exp_resp);
        int         waited;
        int         hold;
        logic [1:0] held_resp;
        logic       aw_seen;
        logic       w_seen;
        awaddr  = addr[addr_width-1:0];
        wdata   = data;
        wstrb   = strb;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        waited  = 0;
        do begin
            @(posedge clk);
            aw_seen = awready;
            w_seen  = wready;
            @(negedge clk);
            waited++;
            if (waited > hs_limit) report_timeout("bvalid");
        end while (!bvalid);
        awvalid = 1'b0;
        wvalid  = 1'b0;
        compare_value("write latency", 32'(waited), 32'd1);
        compare_value("awready", 32'(aw_seen), 32'd1);
        compare_value("wready", 32'(w_seen), 32'd1);
        compare_value("bresp", 32'(bresp), 32'(exp_resp));
        held_resp = bresp;
        hold = pick_stall();
        repeat (hold) begin
            @(negedge clk);
            compare_value("bvalid under stall", 32'(bvalid), 32'd1);
            compare_value("held bresp", 32'(bresp), 32'(held_resp));
        end
        bready = 1'b1;
        @(negedge clk);
        bready = 1'b0;
        compare_value("bvalid after bready", 32'(bvalid), 32'd0);
    endtask

    task automatic axil_read(input logic [31:0] addr, output logic [31:0] data,
                             output logic [1:0] resp);
        int   waited;
        int   hold;
        logic ar_seen;
        araddr  = addr[addr_width-1:0];
        arvalid = 1'b1;
        waited  = 0;
        do begin
            @(posedge clk);
            ar_seen = arready;
            @(negedge clk);
            waited++;
            if (waited > hs_limit) report_timeout("rvalid");
        end while (!rvalid);
        arvalid = 1'b0;
        compare_value("read latency", 32'(waited), 32'd1);
        compare_value("arready", 32'(ar_seen), 32'd1);
        data = rdata;
        resp = rresp;
        hold = pick_stall();
        repeat (hold) begin
            @(negedge clk);
            compare_value("rvalid under stall", 32'(rvalid), 32'd1);
            compare_value("held rdata", rdata, data);
            compare_value("held rresp", 32'(rresp), 32'(resp));
        end
        rready = 1'b1;
        @(negedge clk);
        rready = 1'b0;
        compare_value("rvalid after rready", 32'(rvalid), 32'd0);
    endtask

    task automatic check_read(input logic [31:0] addr, input logic [31:0] exp_data,
                              input logic [1:0] exp_resp);
        logic [31:0] data;
        logic [1:0]  resp;
        axil_read(addr, data, resp);
        compare_value("rdata", data, exp_data);
        compare_value("rresp", 32'(resp), 32'(exp_resp));
        // LED register and port must agree
        if (addr[addr_width-1:0] == reg_led_addr) begin
            compare_value("led port", 32'(led), {24'b0, exp_data[7:0]});
        end
    endtask

    task automatic poll_reg(input logic [31:0] addr, input logic [31:0] value);
        logic [31:0] data;
        logic [1:0]  resp;
        int          tries;
        tries = 0;
        axil_read(addr, data, resp);
        while (data !== value) begin
            tries++;
            if (tries > poll_limit) report_timeout("a polled register value");
            axil_read(addr, data, resp);
        end
    endtask

    initial begin
        int  idx;
        int  base;
        logic done;
        void'($urandom(32'h8ab9fb0f));
        rst_n     = 1'b0;
        drive_pins(13'h0, 2'b11);
        awaddr    = '0;
        awvalid   = 1'b0;
        wdata     = '0;
        wstrb     = '0;
        wvalid    = 1'b0;
        bready    = 1'b0;
        araddr    = '0;
        arvalid   = 1'b0;
        rready    = 1'b0;
        stall_max = 0;
        $readmemh("verification/board_io_testdata.txt", ops);

        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);

        idx  = 0;
        done = 1'b0;
        while (!done) begin
            if (idx == max_ops) begin
                $display("Data file has no end record");
                stop_with_failure();
            end
            base = idx * op_words;
            case (ops[base])
                32'h0: done = 1'b1;
                32'h1: drive_pins(ops[base+1][12:0], ops[base+2][1:0]);
                32'h2: glitch_pins(ops[base+1][12:0], int'(ops[base+2]));
                32'h3: axil_write(ops[base+1], ops[base+2], ops[base+3][3:0],
                                  ops[base+4][1:0]);
                32'h4: check_read(ops[base+1], ops[base+2], ops[base+3][1:0]);
                32'h5: poll_reg(ops[base+1], ops[base+2]);
                32'h6: stall_max = ops[base+1];
                default: begin
                    $display("Unknown operation code %h in data file", ops[base]);
                    stop_with_failure();
                end
            endcase
            idx++;
        end

        if (dut0.regs0.assert0.fail_count == 0) begin
            $display("test passed");
            $finish;
        end else begin
            $display("Bus handshake assertions failed during the run");
            stop_with_failure();
        end
    end

endmodule

`default_nettype wire

//--- verification/board_io_testdata.txt
// Columns (hex): op arg1 arg2 arg3 arg4; op 0 end, 1 pin, 2 glitch, 3 write, 4 read, 5 poll, 6 stall
// pin: gpio uart{rxd,rts}  glitch: gpio clocks  write: addr data strb resp  read: addr data resp
// poll: addr value  stall: most cycles to hold bready or rready low
4 0 30000 0 0
4 4 0 0 0
4 8 0 0 0
4 c 10c40001 0 0
6 3 0 0 0
3 8 aabbcc5a e 0
4 8 0 0 0
3 8 12345678 1 0
4 8 78 0 0
3 8 ffffffa5 e 0
4 8 78 0 0
1 15a5 3 0 0
5 0 315a5 0 0
2 0a5a b 0 0
4 0 315a5 0 0
1 0f0f 3 0 0
5 0 30f0f 0 0
1 0f0f 2 0 0
5 4 1 0 0
4 0 20f0f 0 0
1 0f0f 0 0 0
5 4 5 0 0
4 0 f0f 0 0
1 0f0f 3 0 0
5 4 f 0 0
4 0 30f0f 0 0
3 4 1 1 0
4 4 e 0 0
3 4 8 1 0
4 4 6 0 0
3 4 f e 0
4 4 6 0 0
6 5 0 0 0
3 10 ffffffff f 2
4 8 78 0 0
4 4 6 0 0
4 10 0 2 0
3 f0 12 1 2
4 f0 0 2 0
4 c 10c40001 0 0
6 0 0 0 0
0 0 0 0 0

//--- compile.f
hdl/board_io_pkg.sv
hdl/debounce_switch.sv
hdl/signal_sync_edge.sv
hdl/gpio_axil_regs.sv
hdl/board_io_top.sv
verification/board_io_assert.sv
verification/board_io_tb.sv

//--- Makefile
SIM      := verilator
SIMFLAGS := --binary --timing --assert -Wno-fatal
TOP      := board_io_tb
FILELIST := compile.f
OBJDIR   := obj_dir
PASS_MSG := test passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	./$(OBJDIR)/V$(TOP) | tee /dev/stderr | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)
